//--- aesTypesPkg.sv
`default_nettype none

package aesTypesPkg;

    //**************************************************************************
    // Data layout
    //**************************************************************************

    // One AES byte
    typedef logic [7:0] byteT;

    // Four bytes, byte 0 sits in the most significant position
    typedef byteT [0:3] wordT;

    // One block in FIPS order, filled column by column
    // Byte index is row + 4 * column
    typedef byteT [0:15] stateT;

    // Round keys use the same layout as the state
    typedef stateT roundKeyT;

    // Bytes in one cipher block
    localparam int blockBytes = 16;

    //**************************************************************************
    // Key size helpers
    //**************************************************************************

    // Number of cipher rounds for the given key width
    function automatic int numRoundsOf(input int keySize);
        return (keySize == 256) ? 14 : 10;
    endfunction

    // Key width in bytes
    function automatic int keyBytesOf(input int keySize);
        return keySize / 8;
    endfunction

endpackage

`default_nettype wire

//--- aesFunctionsPkg.sv
`default_nettype none

package aesFunctionsPkg;

    import aesTypesPkg::*;

    //**************************************************************************
    // Tables
    //**************************************************************************

    // Forward S-box, indexed by the input byte
    localparam byteT sbox [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants, entry 0 is never used by the schedule
    localparam byteT rconTable [0:10] = '{
        8'h8d, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    //**************************************************************************
    // Key schedule helpers
    //**************************************************************************

    // Rotate a word one byte towards index 0
    function automatic wordT rot4(input wordT w);
        return {w[1], w[2], w[3], w[0]};
    endfunction

    // S-box on each byte of a word
    function automatic wordT sub4(input wordT w);
        wordT s;
        for (int i = 0; i < 4; i++)
        begin
            s[i] = sbox[w[i]];
        end
        return s;
    endfunction

    // Round constant lookup
    function automatic byteT rconOf(input int idx);
        return rconTable[idx];
    endfunction

    // Core step applied to the last word of each sub key
    function automatic wordT scheduleCore(input wordT w, input int rconIdx);
        wordT t;
        t = sub4(rot4(w));
        // Constant lands on the first byte only
        t[0] = t[0] ^ rconOf(rconIdx);
        return t;
    endfunction

    //**************************************************************************
    // Cipher round helpers
    //**************************************************************************

    // Multiply by x in GF(2^8)
    function automatic byteT xtime(input byteT b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // MixColumns on one column, 2a ^ 3b ^ c ^ d rotated per row
    function automatic wordT mixColumn(input wordT c);
        wordT m;
        for (int i = 0; i < 4; i++)
        begin
            m[i] = xtime(c[i]) ^ xtime(c[(i + 1) % 4]) ^ c[(i + 1) % 4]
                 ^ c[(i + 2) % 4] ^ c[(i + 3) % 4];
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- keyRound.sv
`timescale 1ns/100ps
`default_nettype none

module keyRound
    import aesTypesPkg::*, aesFunctionsPkg::*;
#(
    parameter int keySize = 128,
    parameter int round = 1,
    localparam int keyBytes = keyBytesOf(keySize)
)
(
    input  logic                  clock,
    input  logic                  rstN,
    input  byteT [0:keyBytes-1]   prevSubKey,
    output byteT [0:keyBytes-1]   subKey,
    output roundKeyT              roundKey
);

    // A 256-bit sub key holds two round keys, so odd rounds just reuse it
    localparam bit bubble = (keySize == 256) && (round % 2 == 1);
    // Rcon advances once per real expansion step
    localparam int rconIdx = (keySize == 256) ? round - round / 2 : round;

    byteT [0:keyBytes-1] nextSubKey;
    byteT [0:keyBytes-1] subKeyD;
    roundKeyT            roundKeyD;

    // Next sub key from the previous one
    always_comb
    begin : expand
        wordT carry;
        // First word goes through the core step
        nextSubKey[0 +: 4] = scheduleCore(prevSubKey[keyBytes-4 +: 4], rconIdx)
                           ^ prevSubKey[0 +: 4];
        // XOR cascade over the remaining words
        for (int k = 4; k < keyBytes; k += 4)
        begin
            carry = nextSubKey[k-4 +: 4];
            // Extra S-box step in the middle of a 256-bit key
            if ((keySize == 256) && (k == 16))
            begin
                carry = sub4(carry);
            end
            nextSubKey[k +: 4] = carry ^ prevSubKey[k +: 4];
        end
    end

    // Bubble rounds hand on the upper half and hold the sub key
    assign subKeyD   = bubble ? prevSubKey : nextSubKey;
    assign roundKeyD = bubble ? prevSubKey[keyBytes-blockBytes +: blockBytes]
                              : nextSubKey[0 +: blockBytes];

    always_ff @(posedge clock or negedge rstN)
    begin
        if (!rstN)
        begin
            subKey   <= '0;
            roundKey <= '0;
        end
        else
        begin
            subKey   <= subKeyD;
            roundKey <= roundKeyD;
        end
    end

endmodule

`default_nettype wire

//--- keyExpansion.sv
`timescale 1ns/100ps
`default_nettype none

module keyExpansion
    import aesTypesPkg::*;
#(
    parameter int keySize = 128,
    localparam int keyBytes = keyBytesOf(keySize),
    localparam int numRounds = numRoundsOf(keySize)
)
(
    input  logic                clock,
    input  logic                rstN,
    input  byteT [0:keyBytes-1] key,
    output roundKeyT            roundKeys [0:numRounds]
);

    // Sub key chain, entry i comes out of stage i
    byteT [0:keyBytes-1] subKeys [0:numRounds];

    // Round key 0 is the first block of the key itself
    assign subKeys[0]   = key;
    assign roundKeys[0] = key[0 +: blockBytes];

    // One registered stage per round
    for (genvar i = 1; i <= numRounds; i++)
    begin : gKeyStage
        keyRound #(.keySize(keySize), .round(i)) u_keyRound (
            .clock      (clock),
            .rstN       (rstN),
            .prevSubKey (subKeys[i-1]),
            .subKey     (subKeys[i]),
            .roundKey   (roundKeys[i])
        );
    end

endmodule

`default_nettype wire

//--- cipherRound.sv
`timescale 1ns/100ps
`default_nettype none

module cipherRound
    import aesTypesPkg::*, aesFunctionsPkg::*;
#(
    parameter int keySize = 128,
    parameter int round = 0,
    localparam int numRounds = numRoundsOf(keySize)
)
(
    input  logic     clock,
    input  logic     rstN,
    input  logic     validIn,
    input  stateT    stateIn,
    input  roundKeyT roundKey,
    output logic     validOut,
    output stateT    stateOut
);

    stateT subbed;
    stateT shifted;
    stateT mixed;
    stateT nextState;

    always_comb
    begin
        // SubBytes, one column at a time
        for (int c = 0; c < 4; c++)
        begin
            subbed[4*c +: 4] = sub4(stateIn[4*c +: 4]);
        end
        // ShiftRows, row r moves r columns to the left
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                shifted[r + 4*c] = subbed[r + 4*((c + r) % 4)];
            end
        end
        // MixColumns, left out in the last round
        for (int c = 0; c < 4; c++)
        begin
            mixed[4*c +: 4] = (round == numRounds) ? shifted[4*c +: 4]
                                                   : mixColumn(shifted[4*c +: 4]);
        end
        // AddRoundKey, the initial stage only whitens the input
        nextState = ((round == 0) ? stateIn : mixed) ^ roundKey;
    end

    always_ff @(posedge clock or negedge rstN)
    begin
        if (!rstN)
        begin
            validOut <= 1'b0;
            stateOut <= '0;
        end
        else
        begin
            validOut <= validIn;
            stateOut <= nextState;
        end
    end

endmodule

`default_nettype wire

//--- aesEncryptPipe.sv
`timescale 1ns/100ps
`default_nettype none

module aesEncryptPipe
    import aesTypesPkg::*;
#(
    parameter int keySize = 128,
    localparam int keyBytes = keyBytesOf(keySize),
    localparam int numRounds = numRoundsOf(keySize)
)
(
    input  logic                clock,
    input  logic                rstN,
    input  logic                inValid,
    input  byteT [0:keyBytes-1] key,
    input  stateT               plaintext,
    output logic                outValid,
    output stateT               ciphertext
);

    //**************************************************************************
    // Key chain
    //**************************************************************************

    // Round key i is ready i cycles after the key enters
    roundKeyT roundKeys [0:numRounds];

    keyExpansion #(.keySize(keySize)) u_keyExpansion (
        .clock     (clock),
        .rstN      (rstN),
        .key       (key),
        .roundKeys (roundKeys)
    );

    //**************************************************************************
    // State chain
    //**************************************************************************

    // Entry i feeds cipher stage i
    logic  validChain [0:numRounds+1];
    stateT stateChain [0:numRounds+1];

    assign validChain[0] = inValid;
    assign stateChain[0] = plaintext;

    // Stage 0 whitens, stages 1..numRounds run the cipher rounds
    for (genvar i = 0; i <= numRounds; i++)
    begin : gCipherStage
        cipherRound #(.keySize(keySize), .round(i)) u_cipherRound (
            .clock    (clock),
            .rstN     (rstN),
            .validIn  (validChain[i]),
            .stateIn  (stateChain[i]),
            .roundKey (roundKeys[i]),
            .validOut (validChain[i+1]),
            .stateOut (stateChain[i+1])
        );
    end

    // Last stage drives the outputs
    assign outValid   = validChain[numRounds+1];
    assign ciphertext = stateChain[numRounds+1];

endmodule

`default_nettype wire

//--- aesEncryptPipe_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module aesEncryptPipe_assertions
    import aesTypesPkg::*;
#(
    parameter int keySize = 128,
    localparam int latency = numRoundsOf(keySize) + 1
)
(
    input logic  clock,
    input logic  rstN,
    input logic  inValid,
    input logic  outValid,
    input stateT ciphertext
);

    // Cycles since reset release, full once the pipe holds only fresh inputs
    int settle;

    always_ff @(posedge clock or negedge rstN)
    begin
        if (!rstN)
            settle <= 0;
        else if (settle < latency)
            settle <= settle + 1;
    end

    resetQuiet: assert property (@(posedge clock) !rstN |-> !outValid)
        else $error("outValid high while in reset");

    // Output valid is the input valid shifted through every stage
    validDelay: assert property (@(posedge clock) disable iff (!rstN)
        (settle == latency) |-> (outValid == $past(inValid, latency)))
        else $error("outValid does not follow inValid by the pipeline latency");

    knownData: assert property (@(posedge clock) disable iff (!rstN)
        outValid |-> !$isunknown(ciphertext))
        else $error("ciphertext has unknown bits while outValid is high");

endmodule

bind aesEncryptPipe aesEncryptPipe_assertions #(.keySize(keySize)) u_assertions (
    .clock      (clock),
    .rstN       (rstN),
    .inValid    (inValid),
    .outValid   (outValid),
    .ciphertext (ciphertext)
);

`default_nettype wire

//--- tbAesEncryptPipe.sv
`timescale 1ns/100ps
`default_nettype none

module tbAesEncryptPipe
    import aesTypesPkg::*;
#(
    parameter int keySize = 128
);

    localparam int keyBytes    = keyBytesOf(keySize);
    localparam int numRounds   = numRoundsOf(keySize);
    // Whitening stage plus one stage per round
    localparam int latency     = numRounds + 1;
    localparam int maxGap      = 3;
    localparam int clockPeriod = 8;
    localparam int resetCycles = 4;

    logic                clock;
    logic                rstN;
    logic                inValid;
    byteT [0:keyBytes-1] key;
    stateT               plaintext;
    logic                outValid;
    stateT               ciphertext;

    // Golden vectors for this key size
    // Key, plaintext and ciphertext share one index
    byteT [0:keyBytes-1] vecKey [$];
    stateT               vecPlain [$];
    stateT               vecCipher [$];

    // Ciphertexts still in flight with the oldest at the front
    stateT expQ [$];
    // Input valid pattern delayed once per pipeline stage
    logic [latency-1:0] refValid;

    int watchCycles = 0;

    aesEncryptPipe #(.keySize(keySize)) u_dut (
        .clock      (clock),
        .rstN       (rstN),
        .inValid    (inValid),
        .key        (key),
        .plaintext  (plaintext),
        .outValid   (outValid),
        .ciphertext (ciphertext)
    );

    //**************************************************************************
    // Clock, reference valid and watchdog
    //**************************************************************************

    initial
    begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // Reference valid shifts in inValid once per edge and clears on reset
    always @(posedge clock or negedge rstN)
    begin
        if (!rstN)
            refValid <= '0;
        else
            refValid <= {refValid[latency-2:0], inValid};
    end

    initial
    begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clock);
        failRun("vector stream did not finish");
    end

    //**************************************************************************
    // Checks
    //**************************************************************************

    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkState(input stateT expected, input stateT actual, input string name);
        if (actual !== expected)
        begin
            $display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
            failRun("ciphertext mismatch");
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual, input string name);
        if (actual !== expected)
        begin
            $display("Error at %0t: %s expected %b got %b", $time, name, expected, actual);
            failRun("valid timing mismatch");
        end
    endtask

    // Outputs are compared on the falling edge
    always @(negedge clock)
    begin
        checkValid(refValid[latency-1], outValid, "outValid");
        if (outValid)
        begin
            if (expQ.size() == 0)
                failRun("outValid was high with no block in flight");
            else
                checkState(expQ.pop_front(), ciphertext, "ciphertext");
        end
    end

    //**************************************************************************
    // Stimulus helpers
    //**************************************************************************

    // Each line holds key size, key, plaintext and ciphertext in that order
    // Every field after the key size is hex
    task automatic readGolden();
        int           fd;
        int           ks;
        int           n;
        string        line;
        logic [255:0] kRaw;
        logic [127:0] pRaw;
        logic [127:0] cRaw;
        fd = $fopen("aesGolden.txt", "r");
        if (fd == 0)
            failRun("could not open aesGolden.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            // Skip blank and comment lines
            if (line.len() < 8 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%d %h %h %h", ks, kRaw, pRaw, cRaw);
            if (n != 4)
                failRun("malformed line in aesGolden.txt");
            if (ks == keySize)
            begin
                vecKey.push_back(kRaw[keySize-1:0]);
                vecPlain.push_back(pRaw);
                vecCipher.push_back(cRaw);
            end
        end
        $fclose(fd);
    endtask

    // One block on the next edge
    // inValid stays high until another task lowers it
    task automatic sendVector(input int idx);
        @(posedge clock);
        inValid   <= 1'b1;
        key       <= vecKey[idx];
        plaintext <= vecPlain[idx];
        expQ.push_back(vecCipher[idx]);
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clock);
            inValid <= 1'b0;
        end
    endtask

    // Stop feeding and wait for every block in flight to come out
    task automatic waitDrain();
        int waited;
        waited = 0;
        @(posedge clock);
        inValid <= 1'b0;
        while (expQ.size() != 0 && waited < latency + 4)
        begin
            @(posedge clock);
            waited++;
        end
        if (expQ.size() != 0)
            failRun("pipeline did not drain within its latency");
    endtask

    // Fill the pipe and pull reset while outValid is high
    task automatic resetMidStream();
        for (int i = 0; i < latency + 3; i++)
        begin
            sendVector(i % vecKey.size());
        end
        @(posedge clock);
        rstN    <= 1'b0;
        inValid <= 1'b0;
        // Blocks in flight are lost
        expQ.delete();
        #1;
        checkValid(1'b0, outValid, "outValid");
        repeat (2) @(posedge clock);
        rstN <= 1'b1;
        // Stays low with nothing new coming in
        idleCycles(latency + 2);
        sendVector(0);
        waitDrain();
    endtask

    //**************************************************************************
    // Main sequence
    //**************************************************************************

    initial
    begin
        rstN      = 1'b0;
        inValid   = 1'b0;
        key       = '0;
        plaintext = '0;
        refValid  = '0;
        void'($urandom(23));
        readGolden();
        if (vecKey.size() == 0)
            failRun("no golden vectors for this key size");
        // Upper bound on all phases below plus reset and slack
        watchCycles = vecKey.size() * (latency + maxGap + 8) + 6 * latency + 50;

        repeat (resetCycles) @(posedge clock);
        rstN <= 1'b1;

        // Each vector alone
        for (int i = 0; i < vecKey.size(); i++)
        begin
            sendVector(i);
            waitDrain();
        end

        // Back to back with a new key every cycle
        for (int i = 0; i < vecKey.size(); i++)
        begin
            sendVector(i);
        end
        waitDrain();

        // Random idle gaps between blocks
        for (int i = 0; i < vecKey.size(); i++)
        begin
            sendVector(i);
            idleCycles($urandom % (maxGap + 1));
        end
        waitDrain();

        resetMidStream();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- aesGolden.txt
# keySize key plaintext ciphertext, all but keySize in hex, byte 0 first
# Sources are the FIPS-197 appendix examples and the SP 800-38A ECB vectors
128 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
128 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
128 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
128 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
128 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
128 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
128 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
256 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
256 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
256 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
256 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
256 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
256 0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 dc95c078a2408989ad48a21492842087

//--- filelist.f
aesTypesPkg.sv
aesFunctionsPkg.sv
keyRound.sv
keyExpansion.sv
cipherRound.sv
aesEncryptPipe.sv
aesEncryptPipe_assertions.sv
tbAesEncryptPipe.sv
